// File: common/lsu_pkg.sv
// Shared types and sizes of the load/store unit
// RAM size is fixed here; upper address bits above the RAM are ignored
// Width codes follow the RV32I funct3 field of loads and stores

package lsu_pkg;

	// Data path width
	localparam int WORD_BITS = 32;

	// One data word
	// Base, offset, store data, load data and RAM contents
	typedef logic [WORD_BITS-1:0] word_t;

	// RISC-V load/store width code
	typedef logic [2:0] funct3_t;

	// Width codes, as in the funct3 field
	// Stores only use byte, halfword and word
	localparam funct3_t F3_B  = 3'd0;
	localparam funct3_t F3_H  = 3'd1;
	localparam funct3_t F3_W  = 3'd2;
	// Unsigned load variants
	localparam funct3_t F3_BU = 3'd4;
	localparam funct3_t F3_HU = 3'd5;

	// Byte lane mask, bit i enables byte i of the word
	typedef logic [3:0] byte_en_t;

	// Byte offset inside a word
	typedef logic [1:0] lane_t;

	// RAM depth in words
	localparam int MEM_WORDS = 256;

	// Word index width, log2 of MEM_WORDS
	localparam int MEM_ADDR_BITS = 8;

	// Selects one RAM word
	// Taken from the byte address just above the lane bits
	typedef logic [MEM_ADDR_BITS-1:0] mem_index_t;

	// Mask patterns for lane 0
	// Shifted up by the lane in stage 1
	localparam byte_en_t BE_BYTE = 4'b0001;
	localparam byte_en_t BE_HALF = 4'b0011;
	localparam byte_en_t BE_WORD = 4'b1111;

endpackage

// File: source/lsu_addr_stage.sv
// Stage 1 of the load/store pipeline, one request per cycle, no stall
// Store byte enables are zero for loads and for misaligned stores
// Upper address bits beyond the RAM index are dropped, so accesses wrap
`timescale 1ns/1ps

module lsu_addr_stage (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                req_valid,
	input  logic                req_write,
	input  lsu_pkg::funct3_t    req_funct3,
	input  lsu_pkg::word_t      req_base,
	input  lsu_pkg::word_t      req_offset,
	input  lsu_pkg::word_t      req_wdata,
	output logic                s1_valid,
	output logic                s1_write,
	output lsu_pkg::funct3_t    s1_funct3,
	output lsu_pkg::mem_index_t s1_index,
	output lsu_pkg::lane_t      s1_lane,
	output lsu_pkg::byte_en_t   s1_byte_en,
	output lsu_pkg::word_t      s1_wdata,
	output logic                s1_misaligned
);

	import lsu_pkg::*;

	word_t      eff_addr;
	mem_index_t index;
	lane_t      lane;
	logic       misaligned;
	byte_en_t   lane_mask;
	byte_en_t   byte_en;
	word_t      wdata_shifted;

	// Effective byte address
	assign eff_addr = req_base + req_offset;

	// Word index sits just above the two lane bits
	assign index = eff_addr[MEM_ADDR_BITS+1:2];
	assign lane  = eff_addr[1:0];

	// Halfwords need an even lane, words need lane 0
	always_comb
	begin
		case (req_funct3)
			F3_H, F3_HU: misaligned = lane[0];
			F3_W:        misaligned = (lane != 2'd0);
			default:     misaligned = 1'b0;
		endcase
	end

	// Lane mask for the store width
	always_comb
	begin
		case (req_funct3)
			F3_B:    lane_mask = BE_BYTE << lane;
			F3_H:    lane_mask = BE_HALF << lane;
			F3_W:    lane_mask = BE_WORD;
			// Not a store width, write nothing
			default: lane_mask = '0;
		endcase
	end

	// Only a valid, aligned store writes
	assign byte_en = (req_valid && req_write && !misaligned) ? lane_mask : '0;

	// Move store data up to the addressed lane
	// Bytes outside the mask are don't care
	assign wdata_shifted = req_wdata << {lane, 3'b000};

	// Control bits
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			s1_valid      <= 1'b0;
			s1_write      <= 1'b0;
			s1_byte_en    <= '0;
			s1_misaligned <= 1'b0;
		end
		else
		begin
			s1_valid      <= req_valid;
			s1_write      <= req_valid && req_write;
			s1_byte_en    <= byte_en;
			s1_misaligned <= req_valid && misaligned;
		end
	end

	// Payload, only loaded with a request
	always_ff @(posedge clk)
	begin
		if (req_valid)
		begin
			s1_funct3 <= req_funct3;
			s1_index  <= index;
			s1_lane   <= lane;
			s1_wdata  <= wdata_shifted;
		end
	end

endmodule

// File: data_memory/data_memory.sv
// Word RAM with per-byte write enables
// No reset and no initial contents; write a word before reading it
// Read is combinational and always live
`timescale 1ns/1ps

module data_memory (
	input  logic                clk,
	// Word select for both write and read
	input  lsu_pkg::mem_index_t index,
	// All zero means no write this cycle
	input  lsu_pkg::byte_en_t   byte_en,
	// Already shifted into its lanes
	input  lsu_pkg::word_t      wdata,
	output lsu_pkg::word_t      rdata
);

	import lsu_pkg::*;

	// Storage array
	word_t ram [MEM_WORDS];

	// Byte-wise write on the rising edge
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < $bits(byte_en_t); i++)
		begin
			// Untouched lanes keep their old byte
			if (byte_en[i])
			begin
				ram[index][i*8 +: 8] <= wdata[i*8 +: 8];
			end
		end
	end

	// Asynchronous read
	// A load right after a store to the same word sees the new data,
	// since the store lands on the edge that presents the load's index
	assign rdata = ram[index];

endmodule

// File: source/lsu_load_align.sv
// Stage 3 of the load/store pipeline
// Extracts the addressed byte or halfword and extends it per funct3
// rsp_rdata only changes for aligned loads and holds otherwise
`timescale 1ns/1ps

module lsu_load_align (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             s1_valid,
	input  logic             s1_write,
	input  lsu_pkg::funct3_t s1_funct3,
	input  lsu_pkg::lane_t   s1_lane,
	input  logic             s1_misaligned,
	input  lsu_pkg::word_t   mem_rdata,
	output logic             rsp_valid,
	output lsu_pkg::word_t   rsp_rdata,
	output logic             rsp_misaligned
);

	import lsu_pkg::*;

	word_t lane_word;
	logic  [7:0]  ld_byte;
	logic  [15:0] ld_half;
	word_t load_data;
	logic  load_upd;

	// Bring the addressed lane down to bit 0
	assign lane_word = mem_rdata >> {s1_lane, 3'b000};
	assign ld_byte   = lane_word[7:0];
	assign ld_half   = lane_word[15:0];

	// Extension by width code
	always_comb
	begin
		case (s1_funct3)
			F3_B:    load_data = {{24{ld_byte[7]}}, ld_byte};
			F3_BU:   load_data = {24'd0, ld_byte};
			F3_H:    load_data = {{16{ld_half[15]}}, ld_half};
			F3_HU:   load_data = {16'd0, ld_half};
			// Word and unknown codes pass the word as is
			default: load_data = mem_rdata;
		endcase
	end

	// Capture only for aligned loads
	assign load_upd = s1_valid && !s1_write && !s1_misaligned;

	// Response strobe and flag
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rsp_valid      <= 1'b0;
			rsp_misaligned <= 1'b0;
		end
		else
		begin
			rsp_valid      <= s1_valid;
			rsp_misaligned <= s1_valid && s1_misaligned;
		end
	end

	// Load data register
	always_ff @(posedge clk)
	begin
		if (load_upd)
		begin
			rsp_rdata <= load_data;
		end
	end

endmodule

// File: source/lsu_top.sv
// Three-stage load/store path: address, memory, load alignment
// Fixed two-cycle latency from request to response, no back-pressure
// Misaligned accesses are flagged and their stores dropped, no trap
`timescale 1ns/1ps

module lsu_top (
	input  logic             clk,
	input  logic             rst_n,
	// Request, sampled on the rising edge
	input  logic             req_valid,
	input  logic             req_write,
	input  lsu_pkg::funct3_t req_funct3,
	input  lsu_pkg::word_t   req_base,
	input  lsu_pkg::word_t   req_offset,
	input  lsu_pkg::word_t   req_wdata,
	// Response, in request order
	output logic             rsp_valid,
	output lsu_pkg::word_t   rsp_rdata,
	output logic             rsp_misaligned
);

	import lsu_pkg::*;

	// Stage 1 registers
	logic       s1_valid;
	logic       s1_write;
	funct3_t    s1_funct3;
	mem_index_t s1_index;
	lane_t      s1_lane;
	byte_en_t   s1_byte_en;
	word_t      s1_wdata;
	logic       s1_misaligned;

	// Combinational RAM read
	word_t      mem_rdata;

	lsu_addr_stage i_addr_stage (
		.clk           (clk),
		.rst_n         (rst_n),
		.req_valid     (req_valid),
		.req_write     (req_write),
		.req_funct3    (req_funct3),
		.req_base      (req_base),
		.req_offset    (req_offset),
		.req_wdata     (req_wdata),
		.s1_valid      (s1_valid),
		.s1_write      (s1_write),
		.s1_funct3     (s1_funct3),
		.s1_index      (s1_index),
		.s1_lane       (s1_lane),
		.s1_byte_en    (s1_byte_en),
		.s1_wdata      (s1_wdata),
		.s1_misaligned (s1_misaligned)
	);

	// Store lands one edge after the request
	data_memory i_data_memory (
		.clk     (clk),
		.index   (s1_index),
		.byte_en (s1_byte_en),
		.wdata   (s1_wdata),
		.rdata   (mem_rdata)
	);

	lsu_load_align i_load_align (
		.clk            (clk),
		.rst_n          (rst_n),
		.s1_valid       (s1_valid),
		.s1_write       (s1_write),
		.s1_funct3      (s1_funct3),
		.s1_lane        (s1_lane),
		.s1_misaligned  (s1_misaligned),
		.mem_rdata      (mem_rdata),
		.rsp_valid      (rsp_valid),
		.rsp_rdata      (rsp_rdata),
		.rsp_misaligned (rsp_misaligned)
	);

endmodule

// File: verif/lsu_tb.sv
// Testbench for lsu_top driven by the vectors in verif/lsu_patterns.hex
// Run from the project root so the vector file path resolves
// The RAM has no reset and the vectors store to a word before loading it
`timescale 1ns/1ps

module lsu_tb;

	import lsu_pkg::*;

	// Seven words per vector as listed in the vector file header
	localparam int FIELDS      = 7;
	localparam int MAX_VECTORS = 96;
	localparam int RSP_TIMEOUT = 20;
	localparam int RAM_BYTES   = MEM_WORDS * 4;

	logic    clk = 1'b0;
	logic    rst_n;
	logic    req_valid;
	logic    req_write;
	funct3_t req_funct3;
	word_t   req_base;
	word_t   req_offset;
	word_t   req_wdata;
	logic    rsp_valid;
	word_t   rsp_rdata;
	logic    rsp_misaligned;

	// Raw vector words
	// An all-ones control word ends the list
	word_t vec_words [MAX_VECTORS * FIELDS];

	// Byte image of the RAM as written by the vector stores
	logic [7:0] model_mem [RAM_BYTES];

	// Responses still owed by the DUT in issue order
	word_t exp_rdata_q [$];
	logic  exp_mis_q [$];
	logic  exp_load_q [$];
	int    exp_cycle_q [$];

	// Queue heads at a response
	word_t head_rdata;
	logic  head_mis;
	logic  head_load;
	int    head_cycle;

	// Data of the last aligned load, which rsp_rdata keeps until the next one
	word_t last_rdata;
	logic  have_last = 1'b0;

	int          cycle = 0;
	int          num_rsp = 0;
	int          rsp_errors = 0;
	int          vec_errors;
	int          run_errors;
	int unsigned lcg_state;

	lsu_top i_dut (
		.clk            (clk),
		.rst_n          (rst_n),
		.req_valid      (req_valid),
		.req_write      (req_write),
		.req_funct3     (req_funct3),
		.req_base       (req_base),
		.req_offset     (req_offset),
		.req_wdata      (req_wdata),
		.rsp_valid      (rsp_valid),
		.rsp_rdata      (rsp_rdata),
		.rsp_misaligned (rsp_misaligned)
	);

	// 20 ns clock
	always #10 clk = ~clk;

	// Edge counter for the latency check
	always @(posedge clk)
	begin
		cycle <= cycle + 1;
	end

	function automatic int unsigned next_random(input int unsigned state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	// Halfwords need an even address and words a multiple of four
	function automatic logic is_misaligned(input funct3_t f3, input word_t addr);
		case (f3)
			F3_H, F3_HU: return addr[0];
			F3_W:        return addr[1:0] != 2'b00;
			default:     return 1'b0;
		endcase
	endfunction

	// Little-endian load from the byte image
	// The address wraps at the RAM size
	function automatic word_t model_load(input funct3_t f3, input word_t addr);
		int a;
		a = addr % RAM_BYTES;
		case (f3)
			F3_B:    return {{24{model_mem[a][7]}}, model_mem[a]};
			F3_BU:   return {24'd0, model_mem[a]};
			F3_H:    return {{16{model_mem[a+1][7]}}, model_mem[a+1], model_mem[a]};
			F3_HU:   return {16'd0, model_mem[a+1], model_mem[a]};
			default: return {model_mem[a+3], model_mem[a+2], model_mem[a+1], model_mem[a]};
		endcase
	endfunction

	task automatic model_store(input funct3_t f3, input word_t addr, input word_t data);
		int a;
		int n;
		a = addr % RAM_BYTES;
		case (f3)
			F3_B:    n = 1;
			F3_H:    n = 2;
			F3_W:    n = 4;
			default: n = 0;
		endcase
		for (int i = 0; i < n; i++)
		begin
			model_mem[a+i] = data[i*8 +: 8];
		end
	endtask

	task automatic check_value(input string name, input word_t expected, input word_t actual,
		inout int count);
		if (expected !== actual)
		begin
			count++;
			$display("ERR %s expected %08h actual %08h at cycle %0d", name, expected, actual,
				cycle);
		end
	endtask

	// Entered 2 ns after a rising edge and left 2 ns after the next one
	task automatic issue_vector(input int v);
		logic    wr;
		funct3_t f3;
		word_t   base;
		word_t   offset;
		word_t   wdata;
		word_t   exp_rdata;
		word_t   exp_mis;
		word_t   addr;
		logic    mis;
		wr        = vec_words[v*FIELDS][0];
		f3        = vec_words[v*FIELDS + 1][2:0];
		base      = vec_words[v*FIELDS + 2];
		offset    = vec_words[v*FIELDS + 3];
		wdata     = vec_words[v*FIELDS + 4];
		exp_rdata = vec_words[v*FIELDS + 5];
		exp_mis   = vec_words[v*FIELDS + 6];
		addr      = base + offset;
		mis       = is_misaligned(f3, addr);
		// Vector must agree with the byte model
		check_value("vector exp_misaligned", word_t'(mis), exp_mis, vec_errors);
		if (!wr && !mis)
		begin
			check_value("vector exp_rdata", model_load(f3, addr), exp_rdata, vec_errors);
		end
		if (wr && !mis)
		begin
			model_store(f3, addr, wdata);
		end
		// Response due two edges after the sampling edge
		exp_rdata_q.push_back(exp_rdata);
		exp_mis_q.push_back(exp_mis[0]);
		exp_load_q.push_back(!wr && !exp_mis[0]);
		exp_cycle_q.push_back(cycle + 2);
		req_valid  = 1'b1;
		req_write  = wr;
		req_funct3 = f3;
		req_base   = base;
		req_offset = offset;
		req_wdata  = wdata;
		@(posedge clk);
		#2;
		req_valid = 1'b0;
	endtask

	// Responses sampled mid-cycle on the falling edge
	always @(negedge clk)
	begin
		if (rst_n && rsp_valid)
		begin
			if (exp_cycle_q.size() == 0)
			begin
				rsp_errors++;
				$display("Response at cycle %0d with no request outstanding", cycle);
			end
			else
			begin
				head_rdata = exp_rdata_q.pop_front();
				head_mis   = exp_mis_q.pop_front();
				head_load  = exp_load_q.pop_front();
				head_cycle = exp_cycle_q.pop_front();
				num_rsp++;
				check_value("rsp_valid cycle", word_t'(head_cycle), word_t'(cycle), rsp_errors);
				check_value("rsp_misaligned", word_t'(head_mis), word_t'(rsp_misaligned),
					rsp_errors);
				// Data only defined for aligned loads
				if (head_load)
				begin
					check_value("rsp_rdata", head_rdata, rsp_rdata, rsp_errors);
					last_rdata = head_rdata;
					have_last  = 1'b1;
				end
				else if (have_last)
				begin
					// Stores and misaligned loads leave the data register alone
					check_value("rsp_rdata", last_rdata, rsp_rdata, rsp_errors);
				end
			end
		end
	end

	initial
	begin
		int num_vectors;
		int gap;
		int waited;
		rst_n      = 1'b0;
		req_valid  = 1'b0;
		req_write  = 1'b0;
		req_funct3 = '0;
		req_base   = '0;
		req_offset = '0;
		req_wdata  = '0;
		vec_errors = 0;
		run_errors = 0;
		lcg_state  = 32'd54897;
		for (int i = 0; i < MAX_VECTORS * FIELDS; i++)
		begin
			vec_words[i] = '1;
		end
		$readmemh("verif/lsu_patterns.hex", vec_words);
		num_vectors = 0;
		while (num_vectors < MAX_VECTORS && vec_words[num_vectors * FIELDS] != '1)
		begin
			num_vectors++;
		end
		if (num_vectors == 0)
		begin
			run_errors++;
			$display("No vectors could be read from verif/lsu_patterns.hex");
		end
		// Reset for four cycles
		repeat (4) @(posedge clk);
		#2;
		rst_n = 1'b1;
		@(posedge clk);
		#2;
		for (int v = 0; v < num_vectors; v++)
		begin
			// Ctl bit 1 chains the vector to the previous one
			if (!vec_words[v*FIELDS][1])
			begin
				lcg_state = next_random(lcg_state);
				gap       = (lcg_state >> 16) % 3;
				repeat (gap)
				begin
					@(posedge clk);
					#2;
				end
			end
			issue_vector(v);
		end
		// Drain outstanding responses
		waited = 0;
		while (exp_cycle_q.size() != 0 && waited < RSP_TIMEOUT)
		begin
			@(posedge clk);
			waited++;
		end
		if (exp_cycle_q.size() != 0)
		begin
			run_errors++;
			$display("Timed out after %0d cycles with %0d responses still missing", waited,
				exp_cycle_q.size());
		end
		$display("Vector errors %0d, response errors %0d, run errors %0d, responses %0d of %0d",
			vec_errors, rsp_errors, run_errors, num_rsp, num_vectors);
		if (vec_errors + rsp_errors + run_errors == 0)
		begin
			$display("All tests passed!");
		end
		else
		begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// File: verif/lsu_patterns.hex
// ctl funct3 base offset wdata exp_rdata exp_misaligned, one vector per line
// ctl bit 0 is a store, bit 1 issues the vector right after the previous one
// Word round trip
1 2 00000100 00000000 DEADBEEF 00000000 0
0 2 00000100 00000000 00000000 DEADBEEF 0
1 2 00000040 00000008 12345678 00000000 0
0 2 00000048 00000000 00000000 12345678 0
// Byte and halfword stores merge into one word
1 2 00000200 00000000 00000000 00000000 0
1 0 00000200 00000001 123456AB 00000000 0
1 1 00000200 00000002 9999CDEF 00000000 0
0 2 00000200 00000000 00000000 CDEFAB00 0
1 0 00000203 00000000 000000FF 00000000 0
0 2 00000200 00000000 00000000 FFEFAB00 0
// Sign and zero extension
0 0 00000201 00000000 00000000 FFFFFFAB 0
0 4 00000201 00000000 00000000 000000AB 0
0 1 00000202 00000000 00000000 FFFFFFEF 0
0 5 00000202 00000000 00000000 0000FFEF 0
0 1 00000200 00000000 00000000 FFFFAB00 0
0 5 00000200 00000000 00000000 0000AB00 0
0 0 00000200 00000000 00000000 00000000 0
1 2 00000300 00000000 7FFF1234 00000000 0
0 1 00000300 00000000 00000000 00001234 0
0 1 00000302 00000000 00000000 00007FFF 0
0 0 00000303 00000000 00000000 0000007F 0
// Misaligned accesses, stores dropped
0 1 00000301 00000000 00000000 00000000 1
0 2 00000302 00000000 00000000 00000000 1
0 5 00000303 00000000 00000000 00000000 1
1 2 00000301 00000000 AAAAAAAA 00000000 1
1 1 00000303 00000000 00005555 00000000 1
0 2 00000300 00000000 00000000 7FFF1234 0
// Back to back, loads right behind stores
1 2 00000010 00000000 CAFEF00D 00000000 0
2 2 00000010 00000000 00000000 CAFEF00D 0
3 0 00000011 00000000 FFFFFF55 00000000 0
2 2 00000010 00000000 00000000 CAFE550D 0
3 1 00000012 00000000 0000BEEF 00000000 0
2 4 00000013 00000000 00000000 000000BE 0
2 1 00000012 00000000 00000000 FFFFBEEF 0
2 2 00000048 00000000 00000000 12345678 0
// Negative offsets and wrap above the RAM size
1 2 00000110 FFFFFFF0 11223344 00000000 0
0 2 00000200 FFFFFF00 00000000 11223344 0
1 2 00000400 00000004 2468B5E1 00000000 0
0 2 00000004 00000000 00000000 2468B5E1 0
0 2 00001000 00000004 00000000 2468B5E1 0
0 0 FFFFFC05 00000000 00000000 FFFFFFB5 0

// File: lsu_top.f
common/lsu_pkg.sv
source/lsu_addr_stage.sv
data_memory/data_memory.sv
source/lsu_load_align.sv
source/lsu_top.sv
verif/lsu_tb.sv

// File: Makefile
# Verilator build and run of the load/store unit testbench

.PHONY: sim clean

sim:
	verilator --binary --timing -f lsu_top.f --top-module lsu_tb -Mdir obj_dir -o lsu_sim
	./obj_dir/lsu_sim | awk '{ print } /All tests passed!/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
